// ==== src/pulse_counter_pkg.sv ====
package pulse_counter_pkg;

  // Bus and address map
  localparam int axi_data_width = 32;
  localparam int axi_addr_width = 16;
  localparam int addr_lsb = 2;

  localparam int cfg_words = 2;
  localparam int sts_words = 4;
  localparam int cfg_width = cfg_words * axi_data_width;
  localparam int sts_width = sts_words * axi_data_width;
  localparam int cfg_idx_width = $clog2(cfg_words);
  localparam int sts_idx_width = $clog2(sts_words);

  localparam logic [1:0] axi_resp_okay = 2'b00;

  typedef enum logic [1:0] {
    cmd_idle,
    cmd_run,
    cmd_hold,
    cmd_clear
  } cmd_e;

  typedef enum logic [1:0] {
    st_stopped,
    st_counting,
    st_frozen
  } counter_state_e;

  // Word 1 on top, word 0 at the bottom
  typedef struct packed {
    logic [axi_data_width-1:0]                  gate_length;
    logic [cfg_width-axi_data_width-3:0]        reserved;
    cmd_e                                       cmd;
  } cfg_t;

  typedef struct packed {
    logic [sts_width-3*axi_data_width-3:0]      state_pad;
    counter_state_e                             state;
    logic [axi_data_width-1:0]                  windows_done;
    logic [axi_data_width-1:0]                  last_count;
    logic [axi_data_width-1:0]                  live_count;
  } sts_t;

  typedef struct packed {
    logic [axi_addr_width-1:0] addr;
  } axi_addr_t;

  typedef struct packed {
    logic [axi_data_width-1:0] data;
  } axi_wdata_t;

  typedef struct packed {
    logic [axi_data_width-1:0] data;
    logic [1:0]                resp;
  } axi_rdata_t;

endpackage

// ==== src/axi_cfg_register.sv ====
`timescale 1ns/1ps

module axi_cfg_register
(
  input  logic                          aclk,
  input  logic                          aresetn,
  input  pulse_counter_pkg::axi_addr_t  awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  pulse_counter_pkg::axi_wdata_t wdata,
  input  logic                          wvalid,
  output logic                          wready,
  output logic                          bvalid,
  output logic [1:0]                    bresp,
  input  logic                          bready,
  input  pulse_counter_pkg::axi_addr_t  araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic                          rvalid,
  output pulse_counter_pkg::axi_rdata_t rdata,
  input  logic                          rready,
  output pulse_counter_pkg::cfg_t       cfg
);
  import pulse_counter_pkg::*;

  logic [cfg_words-1:0][axi_data_width-1:0] cfg_q;
  logic                                     wr_ready;
  logic                                     wr_fire;
  logic                                     bvalid_q;

  logic [axi_data_width-1:0] sel_word;
  logic [axi_data_width-1:0] held_word_q;
  logic [axi_data_width-1:0] rdata_q;
  logic                      arready_q;
  logic                      rvalid_q;
  logic                      ar_pending;
  logic                      r_free;

  // Address and data are taken together once the response slot is free
  assign wr_ready = ~bvalid_q | bready;
  assign wr_fire  = awvalid & wvalid & wr_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cfg_q[0] <= axi_data_width'(cmd_idle);
      cfg_q[1] <= axi_data_width'(2);
      bvalid_q <= 1'b0;
    end
    else
    begin
      if (wr_fire)
      begin
        cfg_q[awaddr.addr[addr_lsb +: cfg_idx_width]] <= wdata.data;
      end
      bvalid_q <= wr_fire | (bvalid_q & ~bready);
    end
  end

  // Read path
  assign sel_word   = cfg_q[araddr.addr[addr_lsb +: cfg_idx_width]];
  assign ar_pending = ~arready_q | arvalid;
  assign r_free     = ~rvalid_q | rready;

  always_ff @(posedge aclk)
  begin
    if (arready_q)
    begin
      held_word_q <= sel_word;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      arready_q <= 1'b1;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      arready_q <= ~ar_pending | r_free;
      rvalid_q  <= ~r_free | ar_pending;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (ar_pending && r_free)
    begin
      rdata_q <= arready_q ? sel_word : held_word_q;
    end
  end

  assign awready    = wr_ready;
  assign wready     = wr_ready;
  assign bvalid     = bvalid_q;
  assign bresp      = axi_resp_okay;
  assign arready    = arready_q;
  assign rvalid     = rvalid_q;
  assign rdata.data = rdata_q;
  assign rdata.resp = axi_resp_okay;
  assign cfg        = cfg_t'(cfg_q);

endmodule

// ==== src/axi_sts_register.sv ====
`timescale 1ns/1ps

module axi_sts_register
(
  input  logic                          aclk,
  input  logic                          aresetn,
  input  pulse_counter_pkg::sts_t       sts,
  input  pulse_counter_pkg::axi_addr_t  araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output pulse_counter_pkg::axi_rdata_t rdata,
  output logic                          rvalid,
  input  logic                          rready
);
  import pulse_counter_pkg::*;

  logic [sts_words-1:0][axi_data_width-1:0] word_array;
  logic [axi_data_width-1:0]                sel_word;
  logic [axi_data_width-1:0]                held_word_q;
  logic [axi_data_width-1:0]                rdata_q;
  logic                                     arready_q;
  logic                                     rvalid_q;
  logic                                     ar_pending;
  logic                                     r_free;

  assign word_array = sts;

  // Index wraps since only the bits above the byte offset are used
  assign sel_word = word_array[araddr.addr[addr_lsb +: sts_idx_width]];

  // A read waits to be moved out, or the r slot can take one this cycle
  assign ar_pending = ~arready_q | arvalid;
  assign r_free     = ~rvalid_q | rready;

  // Word as it was at the ar transfer, kept while the response stalls
  always_ff @(posedge aclk)
  begin
    if (arready_q)
    begin
      held_word_q <= sel_word;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      arready_q <= 1'b1;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      arready_q <= ~ar_pending | r_free;
      rvalid_q  <= ~r_free | ar_pending;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (ar_pending && r_free)
    begin
      rdata_q <= arready_q ? sel_word : held_word_q;
    end
  end

  assign arready    = arready_q;
  assign rvalid     = rvalid_q;
  assign rdata.data = rdata_q;
  assign rdata.resp = axi_resp_okay;

endmodule

// ==== src/gated_pulse_counter.sv ====
`timescale 1ns/1ps

module gated_pulse_counter
(
  input  logic                    aclk,
  input  logic                    aresetn,
  input  pulse_counter_pkg::cfg_t cfg,
  input  logic                    pulse_in,
  output pulse_counter_pkg::sts_t sts
);
  import pulse_counter_pkg::*;

  counter_state_e            state_q;
  cmd_e                      cmd_q;
  logic                      pulse_prev_q;
  logic                      rise;
  logic                      window_end;
  logic [axi_data_width-1:0] gate_len;
  logic [axi_data_width-1:0] timer_q;
  logic [axi_data_width-1:0] live_q;
  logic [axi_data_width-1:0] last_q;
  logic [axi_data_width-1:0] windows_q;

  // Windows shorter than 2 cycles are stretched to 2
  assign gate_len = (cfg.gate_length < axi_data_width'(2)) ? axi_data_width'(2)
                                                           : cfg.gate_length;

  assign rise       = pulse_in & ~pulse_prev_q;
  assign window_end = (state_q == st_counting) && (timer_q == gate_len - 1'b1);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q      <= st_stopped;
      cmd_q        <= cmd_idle;
      pulse_prev_q <= 1'b0;
      timer_q      <= '0;
      live_q       <= '0;
      last_q       <= '0;
      windows_q    <= '0;
    end
    else
    begin
      // Command goes through one register stage before it acts
      cmd_q        <= cfg.cmd;
      pulse_prev_q <= pulse_in;

      if (state_q == st_counting)
      begin
        if (window_end)
        begin
          last_q    <= live_q + axi_data_width'(rise);
          live_q    <= '0;
          windows_q <= windows_q + 1'b1;
          timer_q   <= '0;
        end
        else
        begin
          live_q  <= live_q + axi_data_width'(rise);
          timer_q <= timer_q + 1'b1;
        end
      end

      case (cmd_q)
        cmd_run:
        begin
          state_q <= st_counting;
          // A fresh start opens a new window, a resume from frozen does not
          if (state_q == st_stopped)
          begin
            timer_q <= '0;
            live_q  <= '0;
          end
        end
        cmd_hold:
        begin
          state_q <= st_frozen;
        end
        cmd_clear:
        begin
          state_q   <= st_stopped;
          timer_q   <= '0;
          live_q    <= '0;
          last_q    <= '0;
          windows_q <= '0;
        end
        default:
        begin
          state_q <= st_stopped;
        end
      endcase
    end
  end

  always_comb
  begin
    sts.live_count   = live_q;
    sts.last_count   = last_q;
    sts.windows_done = windows_q;
    sts.state        = state_q;
    sts.state_pad    = '0;
  end

endmodule

// ==== src/pulse_counter_system.sv ====
`timescale 1ns/1ps

module pulse_counter_system
(
  input  logic                          aclk,
  input  logic                          aresetn,
  input  pulse_counter_pkg::axi_addr_t  cfg_awaddr,
  input  logic                          cfg_awvalid,
  output logic                          cfg_awready,
  input  pulse_counter_pkg::axi_wdata_t cfg_wdata,
  input  logic                          cfg_wvalid,
  output logic                          cfg_wready,
  output logic                          cfg_bvalid,
  output logic [1:0]                    cfg_bresp,
  input  logic                          cfg_bready,
  input  pulse_counter_pkg::axi_addr_t  cfg_araddr,
  input  logic                          cfg_arvalid,
  output logic                          cfg_arready,
  output logic                          cfg_rvalid,
  output pulse_counter_pkg::axi_rdata_t cfg_rdata,
  input  logic                          cfg_rready,
  input  pulse_counter_pkg::axi_addr_t  sts_araddr,
  input  logic                          sts_arvalid,
  output logic                          sts_arready,
  output logic                          sts_rvalid,
  output pulse_counter_pkg::axi_rdata_t sts_rdata,
  input  logic                          sts_rready,
  input  logic                          pulse_in
);
  import pulse_counter_pkg::*;

  cfg_t cfg_bus;
  sts_t sts_bus;

  axi_cfg_register u_cfg
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .awaddr  (cfg_awaddr),
    .awvalid (cfg_awvalid),
    .awready (cfg_awready),
    .wdata   (cfg_wdata),
    .wvalid  (cfg_wvalid),
    .wready  (cfg_wready),
    .bvalid  (cfg_bvalid),
    .bresp   (cfg_bresp),
    .bready  (cfg_bready),
    .araddr  (cfg_araddr),
    .arvalid (cfg_arvalid),
    .arready (cfg_arready),
    .rvalid  (cfg_rvalid),
    .rdata   (cfg_rdata),
    .rready  (cfg_rready),
    .cfg     (cfg_bus)
  );

  gated_pulse_counter u_counter
  (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cfg      (cfg_bus),
    .pulse_in (pulse_in),
    .sts      (sts_bus)
  );

  axi_sts_register u_sts
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .sts     (sts_bus),
    .araddr  (sts_araddr),
    .arvalid (sts_arvalid),
    .arready (sts_arready),
    .rdata   (sts_rdata),
    .rvalid  (sts_rvalid),
    .rready  (sts_rready)
  );

endmodule

// ==== verification/pulse_counter_system_assertions.sv ====
`timescale 1ns/1ps

module pulse_counter_system_assertions
(
  input logic                          aclk,
  input logic                          aresetn,
  input logic                          cfg_bvalid,
  input logic                          cfg_bready,
  input logic                          cfg_rvalid,
  input logic                          cfg_rready,
  input pulse_counter_pkg::axi_rdata_t cfg_rdata,
  input logic                          sts_rvalid,
  input logic                          sts_rready,
  input pulse_counter_pkg::axi_rdata_t sts_rdata
);

  cfg_r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    cfg_rvalid && !cfg_rready |=> cfg_rvalid && $stable(cfg_rdata))
    else $error("cfg read response changed before rready");

  sts_r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    sts_rvalid && !sts_rready |=> sts_rvalid && $stable(sts_rdata))
    else $error("sts read response changed before rready");

  cfg_b_held: assert property (@(posedge aclk) disable iff (!aresetn)
    cfg_bvalid && !cfg_bready |=> cfg_bvalid)
    else $error("cfg write response dropped before bready");

  // First cycle out of reset has no response pending
  reset_idle: assert property (@(posedge aclk)
    $rose(aresetn) |-> !cfg_bvalid && !cfg_rvalid && !sts_rvalid)
    else $error("response valid set right after reset");

endmodule

bind pulse_counter_system pulse_counter_system_assertions u_assertions
(
  .aclk       (aclk),
  .aresetn    (aresetn),
  .cfg_bvalid (cfg_bvalid),
  .cfg_bready (cfg_bready),
  .cfg_rvalid (cfg_rvalid),
  .cfg_rready (cfg_rready),
  .cfg_rdata  (cfg_rdata),
  .sts_rvalid (sts_rvalid),
  .sts_rready (sts_rready),
  .sts_rdata  (sts_rdata)
);

// ==== verification/pulse_counter_system_tb.sv ====
`timescale 1ns/1ps

module pulse_counter_system_tb;
  import pulse_counter_pkg::*;

  localparam int num_rows     = 6;
  localparam int reset_cycles = 8;
  localparam int max_gate     = 400;
  localparam int cycle_limit  = 2 * (num_rows * (max_gate + 200) + reset_cycles);

  logic       aclk = 1'b0;
  logic       aresetn;
  axi_addr_t  cfg_awaddr;
  logic       cfg_awvalid;
  logic       cfg_awready;
  axi_wdata_t cfg_wdata;
  logic       cfg_wvalid;
  logic       cfg_wready;
  logic       cfg_bvalid;
  logic [1:0] cfg_bresp;
  logic       cfg_bready;
  axi_addr_t  cfg_araddr;
  logic       cfg_arvalid;
  logic       cfg_arready;
  logic       cfg_rvalid;
  axi_rdata_t cfg_rdata;
  logic       cfg_rready;
  axi_addr_t  sts_araddr;
  logic       sts_arvalid;
  logic       sts_arready;
  logic       sts_rvalid;
  axi_rdata_t sts_rdata;
  logic       sts_rready;
  logic       pulse_in;

  int          cycle_count  = 0;
  int          test_errors  = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic [31:0] lcg_state    = 32'd73029;

  // A pulse count of -1 takes its value from the LCG
  string row_name [num_rows] = '{"single_pulse", "ten_pulses", "forty_pulses",
                                 "random_a", "random_b", "random_c"};
  cmd_e  row_cmd [num_rows]     = '{cmd_run, cmd_run, cmd_run, cmd_run, cmd_run, cmd_run};
  int    row_gate [num_rows]    = '{400, 400, 400, 400, 300, 250};
  int    row_pulses [num_rows]  = '{1, 10, 40, -1, -1, -1};
  int    row_windows [num_rows] = '{1, 1, 1, 1, 1, 1};

  pulse_counter_system dut (.*);

  always #4 aclk = ~aclk;

  always @(posedge aclk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the run hung", cycle_count);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic step();
    @(posedge aclk);
    #1;
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("FAILED %s %s: expected %0d, actual %0d", test, field, expected, actual);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0)
    begin
      $display("test %s passed", name);
      tests_passed++;
    end
    else
    begin
      $display("test %s failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic cfg_write(input int idx, input logic [31:0] data);
    logic accepted;
    logic got_resp;
    accepted = 1'b0;
    got_resp = 1'b0;
    cfg_awaddr.addr = 16'(idx << addr_lsb);
    cfg_wdata.data  = data;
    cfg_awvalid     = 1'b1;
    cfg_wvalid      = 1'b1;
    while (!accepted)
    begin
      @(negedge aclk);
      accepted = cfg_awready && cfg_wready;
      step();
    end
    cfg_awvalid = 1'b0;
    cfg_wvalid  = 1'b0;
    // A seen bvalid moves on the next edge unless bready is held low
    while (!got_resp)
    begin
      @(negedge aclk);
      got_resp = cfg_bvalid;
      if (got_resp && cfg_bresp !== axi_resp_okay)
      begin
        $display("Write to cfg word %0d returned a response other than OKAY", idx);
        test_errors++;
      end
      step();
    end
  endtask

  task automatic cfg_read(input int idx, output logic [31:0] data);
    logic accepted;
    logic got_resp;
    accepted = 1'b0;
    got_resp = 1'b0;
    cfg_araddr.addr = 16'(idx << addr_lsb);
    cfg_arvalid     = 1'b1;
    while (!accepted)
    begin
      @(negedge aclk);
      accepted = cfg_arready;
      step();
    end
    cfg_arvalid = 1'b0;
    while (!got_resp)
    begin
      @(negedge aclk);
      got_resp = cfg_rvalid;
      data     = cfg_rdata.data;
      if (got_resp && cfg_rdata.resp !== axi_resp_okay)
      begin
        $display("Read of cfg word %0d returned a response other than OKAY", idx);
        test_errors++;
      end
      step();
    end
  endtask

  task automatic sts_read(input int idx, output logic [31:0] data);
    logic accepted;
    logic got_resp;
    accepted = 1'b0;
    got_resp = 1'b0;
    sts_araddr.addr = 16'(idx << addr_lsb);
    sts_arvalid     = 1'b1;
    while (!accepted)
    begin
      @(negedge aclk);
      accepted = sts_arready;
      step();
    end
    sts_arvalid = 1'b0;
    while (!got_resp)
    begin
      @(negedge aclk);
      got_resp = sts_rvalid;
      data     = sts_rdata.data;
      if (got_resp && sts_rdata.resp !== axi_resp_okay)
      begin
        $display("Read of sts word %0d returned a response other than OKAY", idx);
        test_errors++;
      end
      step();
    end
  endtask

  task automatic drive_pulses(input int count);
    repeat (count)
    begin
      pulse_in = 1'b1;
      step();
      pulse_in = 1'b0;
      step();
    end
  endtask

  task automatic wait_windows(input logic [31:0] target);
    logic [31:0] seen;
    seen = '0;
    while (seen < target)
    begin
      sts_read(2, seen);
    end
  endtask

  // Clear, load the window length, then issue the command
  task automatic restart(input cmd_e cmd, input int gate);
    cfg_write(0, 32'(cmd_clear));
    cfg_write(1, 32'(gate));
    cfg_write(0, 32'(cmd));
    repeat (2) step();
  endtask

  initial
  begin
    logic [31:0] rd;
    logic [31:0] first;
    logic [31:0] burst_data [sts_words+1];
    logic [31:0] frozen_words [sts_words];
    logic        accepted;
    logic        got_resp;
    int          pulses;
    aresetn     = 1'b0;
    cfg_awaddr  = '0;
    cfg_awvalid = 1'b0;
    cfg_wdata   = '0;
    cfg_wvalid  = 1'b0;
    cfg_bready  = 1'b1;
    cfg_araddr  = '0;
    cfg_arvalid = 1'b0;
    cfg_rready  = 1'b1;
    sts_araddr  = '0;
    sts_arvalid = 1'b0;
    sts_rready  = 1'b1;
    pulse_in    = 1'b0;
    repeat (reset_cycles) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    step();

    cfg_read(0, rd);
    if (rd !== 32'(cmd_idle)) report_mismatch("reset_defaults", "cfg word 0", cmd_idle, rd);
    cfg_read(1, rd);
    if (rd !== 32'd2) report_mismatch("reset_defaults", "cfg word 1", 2, rd);
    for (int i = 0; i < sts_words; i++)
    begin
      sts_read(i, rd);
      if (rd !== 32'(i == 3 ? st_stopped : 0))
        report_mismatch("reset_defaults", "sts word", 0, rd);
    end
    finish_test("reset_defaults");

    // Responses are held back for a few cycles on both cfg channels
    cfg_bready = 1'b0;
    cfg_write(0, 32'hA5A5_5A54);
    repeat (2) step();
    cfg_bready = 1'b1;
    cfg_write(1, 32'h0001_2345);
    cfg_read(0, rd);
    if (rd !== 32'hA5A5_5A54) report_mismatch("cfg_readback", "word 0", 32'hA5A5_5A54, rd);
    cfg_rready = 1'b0;
    cfg_read(1, rd);
    repeat (2) step();
    cfg_rready = 1'b1;
    if (rd !== 32'h0001_2345) report_mismatch("cfg_readback", "word 1", 32'h0001_2345, rd);
    finish_test("cfg_readback");

    for (int r = 0; r < num_rows; r++)
    begin
      pulses = row_pulses[r];
      if (pulses < 0)
      begin
        lcg_state = lcg_next(lcg_state);
        pulses    = 1 + int'((lcg_state >> 16) % 32'd40);
      end
      restart(row_cmd[r], row_gate[r]);
      drive_pulses(pulses);
      wait_windows(1);
      sts_read(1, rd);
      if (rd !== 32'(pulses)) report_mismatch(row_name[r], "last_count", pulses, rd);
      sts_read(2, rd);
      if (rd !== 32'(row_windows[r])) report_mismatch(row_name[r], "windows_done",
                                                      row_windows[r], rd);
      finish_test(row_name[r]);
    end

    restart(cmd_run, 400);
    drive_pulses(5);
    cfg_write(0, 32'(cmd_hold));
    repeat (2) step();
    sts_read(0, first);
    // Edges during the hold are not counted
    drive_pulses(25);
    sts_read(0, rd);
    if (first !== 32'd5) report_mismatch("hold_resume", "live_count frozen", 5, first);
    if (rd !== first) report_mismatch("hold_resume", "live_count 50 cycles later", first, rd);
    sts_read(3, rd);
    if (rd !== 32'(st_frozen)) report_mismatch("hold_resume", "state", st_frozen, rd);
    cfg_write(0, 32'(cmd_run));
    repeat (2) step();
    drive_pulses(7);
    wait_windows(1);
    sts_read(1, rd);
    if (rd !== 32'd12) report_mismatch("hold_resume", "last_count", 12, rd);
    finish_test("hold_resume");

    // Freeze with every status word distinct before the burst
    restart(cmd_run, 60);
    drive_pulses(3);
    wait_windows(1);
    drive_pulses(2);
    cfg_write(0, 32'(cmd_hold));
    repeat (2) step();
    frozen_words = '{32'd2, 32'd3, 32'd1, 32'(st_frozen)};
    sts_rready   = 1'b0;
    fork
      begin
        for (int a = 0; a <= sts_words; a++)
        begin
          sts_araddr.addr = 16'(a << addr_lsb);
          sts_arvalid     = 1'b1;
          accepted        = 1'b0;
          while (!accepted)
          begin
            @(negedge aclk);
            accepted = sts_arready;
            step();
          end
        end
        sts_arvalid = 1'b0;
      end
      begin
        repeat (4) step();
        sts_rready = 1'b1;
        for (int n = 0; n <= sts_words; n++)
        begin
          got_resp = 1'b0;
          while (!got_resp)
          begin
            @(negedge aclk);
            got_resp      = sts_rvalid;
            burst_data[n] = sts_rdata.data;
            step();
          end
        end
      end
    join
    for (int n = 0; n <= sts_words; n++)
    begin
      if (burst_data[n] !== frozen_words[n % sts_words])
        report_mismatch("status_burst", "word", frozen_words[n % sts_words], burst_data[n]);
    end
    finish_test("status_burst");

    restart(cmd_run, 20);
    drive_pulses(4);
    wait_windows(3);
    cfg_write(0, 32'(cmd_clear));
    repeat (2) step();
    for (int i = 0; i < sts_words; i++)
    begin
      sts_read(i, rd);
      if (rd !== 32'(i == 3 ? st_stopped : 0)) report_mismatch("clear_after_windows",
                                                               "sts word", 0, rd);
    end
    finish_test("clear_after_windows");

    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
src/pulse_counter_pkg.sv
src/axi_cfg_register.sv
src/axi_sts_register.sv
src/gated_pulse_counter.sv
src/pulse_counter_system.sv
verification/pulse_counter_system_assertions.sv
verification/pulse_counter_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pulse counter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module pulse_counter_system_tb \
  -f flist.f \
  -o pulse_counter_sim

./obj_dir/pulse_counter_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Some tests failed" sim.log
then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
